// File: include/hdcpu_params.svh
`ifndef HDCPU_PARAMS_SVH
`define HDCPU_PARAMS_SVH

// Console switch SW[2:0]
`define HDCPU_SW_W 3

// Opcode field, IR[7:4]
`define HDCPU_OP_W 4

// Beats W1..W3
`define HDCPU_BEAT_W 3

// ALU function select S
`define HDCPU_ALU_S_W 4

// Register file select SEL
`define HDCPU_SEL_W 4

`endif

// File: hdl/hdcpu_pkg.sv
`include "hdcpu_params.svh"

package hdcpu_pkg;

    typedef enum logic [`HDCPU_SW_W-1:0] {
        MODE_EXEC = 3'b000,
        MODE_WMEM = 3'b001,
        MODE_RMEM = 3'b010,
        MODE_RREG = 3'b011,
        MODE_WREG = 3'b100
    } console_mode_e;

    // 1011 (old IRET), 0000 and 1111 are left unnamed
    typedef enum logic [`HDCPU_OP_W-1:0] {
        OP_ADD = 4'b0001,
        OP_SUB = 4'b0010,
        OP_AND = 4'b0011,
        OP_INC = 4'b0100,
        OP_LD  = 4'b0101,
        OP_ST  = 4'b0110,
        OP_JC  = 4'b0111,
        OP_JZ  = 4'b1000,
        OP_JMP = 4'b1001,
        OP_OUT = 4'b1010,
        OP_OR  = 4'b1100,
        OP_XOR = 4'b1101,
        OP_STP = 4'b1110
    } opcode_e;

    typedef struct packed {
        console_mode_e             mode;
        opcode_e                   op;
        logic [`HDCPU_BEAT_W-1:0]  w;   // w[0] is W1
        logic                      c;
        logic                      z;
        logic                      st0;
    } beat_t;

    typedef struct packed {
        logic set;
        logic clr;
    } st0_cmd_t;

    typedef struct packed {
        logic                       ldc;
        logic                       ldz;
        logic                       cin;
        logic [`HDCPU_ALU_S_W-1:0]  s;
        logic [`HDCPU_SEL_W-1:0]    sel;
        logic                       m;
        logic                       abus;
        logic                       drw;
        logic                       pcinc;
        logic                       lpc;
        logic                       lar;
        logic                       pcadd;
        logic                       arinc;
        logic                       selctl;
        logic                       memw;
        logic                       stop;
        logic                       lir;
        logic                       sbus;
        logic                       mbus;
        logic                       short;
        logic                       long;
    } ctrl_word_t;

endpackage

// File: hdl/beat_sampler.sv
`timescale 1ns/10ps
`include "hdcpu_params.svh"

module beat_sampler (
    input  logic                      t3,
    input  logic                      arst_n,
    input  logic [`HDCPU_SW_W-1:0]    sw,
    input  logic [`HDCPU_OP_W-1:0]    ir_op,
    input  logic [`HDCPU_BEAT_W-1:0]  w,
    input  logic                      c,
    input  logic                      z,
    input  hdcpu_pkg::st0_cmd_t       st0_cmd,
    output hdcpu_pkg::beat_t          beat
);

    logic st0_next;

    // Set has priority over clear
    always_comb begin
        st0_next = st0_cmd.set | (beat.st0 & ~st0_cmd.clr);
    end

    // ST0 lives in the beat register so the next captured beat carries it
    always_ff @(posedge t3 or negedge arst_n) begin
        if (!arst_n) begin
            beat <= '0;   // MODE_EXEC, no beat
        end else begin
            beat.mode <= hdcpu_pkg::console_mode_e'(sw);
            beat.op   <= hdcpu_pkg::opcode_e'(ir_op);
            beat.w    <= w;
            beat.c    <= c;
            beat.z    <= z;
            beat.st0  <= st0_next;
        end
    end

    // Beat generator drives one of W1..W3 at a time
    a_single_beat : assert property (
        @(posedge t3) disable iff (!arst_n) $onehot0(w)
    ) else $error("more than one beat active: w=%b", w);

endmodule

// File: hdl/console_decoder.sv
`timescale 1ns/10ps

module console_decoder (
    input  hdcpu_pkg::beat_t       beat,
    output hdcpu_pkg::ctrl_word_t  con_word,
    output hdcpu_pkg::st0_cmd_t    st0_cmd
);

    logic w1;
    logic w2;
    logic st0;

    assign w1  = beat.w[0];
    assign w2  = beat.w[1];
    assign st0 = beat.st0;

    always_comb begin
        con_word = '0;
        st0_cmd  = '0;
        case (beat.mode)
            hdcpu_pkg::MODE_WMEM: begin
                // First pass loads AR from switches, later passes write and step AR
                con_word.lar    = w1 & ~st0;
                con_word.memw   = w1 & st0;
                con_word.arinc  = w1 & st0;
                con_word.sbus   = w1;
                con_word.stop   = w1;
                con_word.short  = w1;
                con_word.selctl = w1;
                st0_cmd.set     = w1;
            end
            hdcpu_pkg::MODE_RMEM: begin
                con_word.sbus   = w1 & ~st0;
                con_word.lar    = w1 & ~st0;
                con_word.mbus   = w1 & st0;
                con_word.arinc  = w1 & st0;
                con_word.stop   = w1;
                con_word.short  = w1;
                con_word.selctl = w1;
                st0_cmd.set     = w1 & ~st0;
            end
            hdcpu_pkg::MODE_RREG: begin
                con_word.selctl = w1 | w2;
                con_word.stop   = w1 | w2;
                con_word.sel    = {w2, 1'b0, w2, w1 | w2};  // R0/R1 then R2/R3
            end
            hdcpu_pkg::MODE_WREG: begin
                con_word.sbus   = w1 | w2;
                con_word.selctl = w1 | w2;
                con_word.drw    = w1 | w2;
                con_word.stop   = w1 | w2;
                if (w1 | w2) begin
                    con_word.sel = {st0, w2, (~st0 & w1) | (st0 & w2), w1};
                end
                st0_cmd.set     = w2 & ~st0;
                st0_cmd.clr     = w2 & st0;  // Back to the R0/R1 pass
            end
            default: begin
                // Execution mode and inactive codes
                con_word = '0;
                st0_cmd  = '0;
            end
        endcase
    end

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  hdcpu_pkg::beat_t       beat,
    output hdcpu_pkg::ctrl_word_t  exe_word
);

    logic w1;
    logic w2;
    logic w3;

    assign w1 = beat.w[0];
    assign w2 = beat.w[1];
    assign w3 = beat.w[2];

    always_comb begin
        exe_word       = '0;
        exe_word.lir   = w1;  // Fetch on every opcode
        exe_word.pcinc = w1;
        case (beat.op)
            hdcpu_pkg::OP_ADD: begin
                exe_word.s    = 4'b1001;
                exe_word.cin  = w2;
                exe_word.abus = w2;
                exe_word.drw  = w2;
                exe_word.ldz  = w2;
                exe_word.ldc  = w2;
            end
            hdcpu_pkg::OP_SUB: begin
                exe_word.s    = 4'b0110;
                exe_word.abus = w2;
                exe_word.drw  = w2;
                exe_word.ldz  = w2;
                exe_word.ldc  = w2;
            end
            hdcpu_pkg::OP_AND: begin
                exe_word.m    = w2;
                exe_word.s    = 4'b1011;
                exe_word.abus = w2;
                exe_word.drw  = w2;
                exe_word.ldz  = w2;
            end
            hdcpu_pkg::OP_INC: begin
                exe_word.s    = 4'b0000;
                exe_word.abus = w2;
                exe_word.drw  = w2;
                exe_word.ldz  = w2;
                exe_word.ldc  = w2;
            end
            hdcpu_pkg::OP_LD: begin
                exe_word.m    = w2;
                exe_word.s    = 4'b1010;   // Pass B as address
                exe_word.abus = w2;
                exe_word.lar  = w2;
                exe_word.long = w2;
                exe_word.drw  = w3;
                exe_word.mbus = w3;
            end
            hdcpu_pkg::OP_ST: begin
                exe_word.m    = w2 | w3;
                exe_word.s    = w2 ? 4'b1111 : 4'b1010;  // Address on W2, data on W3
                exe_word.abus = w2 | w3;
                exe_word.lar  = w2;
                exe_word.long = w2;
                exe_word.memw = w3;
            end
            hdcpu_pkg::OP_JC: begin
                exe_word.pcadd = w2 & beat.c;
            end
            hdcpu_pkg::OP_JZ: begin
                exe_word.pcadd = w2 & beat.z;
            end
            hdcpu_pkg::OP_JMP: begin
                exe_word.m    = w2;
                exe_word.s    = 4'b1111;
                exe_word.abus = w2;
                exe_word.lpc  = w2;
            end
            hdcpu_pkg::OP_OUT: begin
                exe_word.m    = w2;
                exe_word.s    = 4'b1010;
                exe_word.abus = w2;
            end
            hdcpu_pkg::OP_OR: begin
                exe_word.m    = w2;
                exe_word.s    = 4'b1110;
                exe_word.abus = w2;
                exe_word.drw  = w2;
                exe_word.ldz  = w2;
            end
            hdcpu_pkg::OP_XOR: begin
                exe_word.m    = w2;
                exe_word.s    = 4'b0110;
                exe_word.abus = w2;
                exe_word.drw  = w2;
                exe_word.ldz  = w2;
            end
            hdcpu_pkg::OP_STP: begin
                exe_word.stop = w2;
            end
            default: begin
                exe_word.s = '0;  // Fetch only
            end
        endcase
        // ALU function only driven during W2/W3
        if (!(w2 | w3)) begin
            exe_word.s = '0;
        end
    end

    // Memory cannot be read and written in the same beat
    a_no_mem_rw : assert property (
        @(beat) !(exe_word.memw && exe_word.mbus)
    ) else $error("memw and mbus both high, op=%b", beat.op);

endmodule

// File: hdl/ctrl_output.sv
`timescale 1ns/10ps

module ctrl_output (
    input  logic                   t3,
    input  logic                   arst_n,
    input  hdcpu_pkg::beat_t       beat,
    input  hdcpu_pkg::ctrl_word_t  con_word,
    input  hdcpu_pkg::ctrl_word_t  exe_word,
    output hdcpu_pkg::ctrl_word_t  ctrl
);

    hdcpu_pkg::ctrl_word_t sel_word;

    always_comb begin
        if (beat.mode == hdcpu_pkg::MODE_EXEC) begin
            sel_word = exe_word;
        end else begin
            sel_word = con_word;   // Console modes and inactive codes
        end
    end

    always_ff @(posedge t3 or negedge arst_n) begin
        if (!arst_n) begin
            ctrl <= '0;
        end else begin
            ctrl <= sel_word;
        end
    end

    // Register write and memory write share the data bus
    a_no_memw_drw : assert property (
        @(posedge t3) disable iff (!arst_n) !(ctrl.memw && ctrl.drw)
    ) else $error("memw and drw both high on ctrl");

    a_no_lpc_pcinc : assert property (
        @(posedge t3) disable iff (!arst_n) !(ctrl.lpc && ctrl.pcinc)
    ) else $error("lpc and pcinc both high on ctrl");

endmodule

// File: hdl/hdcpu_ctrl.sv
`timescale 1ns/10ps
`include "hdcpu_params.svh"

module hdcpu_ctrl (
    input  logic                      t3,
    input  logic                      arst_n,
    input  logic [`HDCPU_SW_W-1:0]    sw,
    input  logic [`HDCPU_OP_W-1:0]    ir_op,
    input  logic [`HDCPU_BEAT_W-1:0]  w,
    input  logic                      c,
    input  logic                      z,
    output hdcpu_pkg::ctrl_word_t     ctrl
);

    hdcpu_pkg::beat_t       beat;
    hdcpu_pkg::st0_cmd_t    st0_cmd;
    hdcpu_pkg::ctrl_word_t  con_word;
    hdcpu_pkg::ctrl_word_t  exe_word;

    beat_sampler u_sampler (
        .t3      (t3),
        .arst_n  (arst_n),
        .sw      (sw),
        .ir_op   (ir_op),
        .w       (w),
        .c       (c),
        .z       (z),
        .st0_cmd (st0_cmd),
        .beat    (beat)
    );

    console_decoder u_con_dec (
        .beat     (beat),
        .con_word (con_word),
        .st0_cmd  (st0_cmd)
    );

    instr_decoder u_exe_dec (
        .beat     (beat),
        .exe_word (exe_word)
    );

    ctrl_output u_out (
        .t3       (t3),
        .arst_n   (arst_n),
        .beat     (beat),
        .con_word (con_word),
        .exe_word (exe_word),
        .ctrl     (ctrl)
    );

endmodule

// File: verif/hdcpu_tb.sv
`timescale 1ns/10ps
`include "hdcpu_params.svh"

module hdcpu_tb;

    logic                      t3 = 1'b0;
    logic                      arst_n = 1'b0;
    logic [`HDCPU_SW_W-1:0]    sw;
    logic [`HDCPU_OP_W-1:0]    ir_op;
    logic [`HDCPU_BEAT_W-1:0]  w;
    logic                      c;
    logic                      z;
    hdcpu_pkg::ctrl_word_t     ctrl;

    hdcpu_pkg::ctrl_word_t  pend_word;
    hdcpu_pkg::ctrl_word_t  cap_word;
    hdcpu_pkg::ctrl_word_t  exp_q[$];   // One entry in flight after capture
    string                  name_q[$];
    string                  pend_name;
    string                  cap_name;
    string                  cur_test;
    logic                   pend_valid = 1'b0;
    logic                   cap_valid = 1'b0;
    logic                   st0_model = 1'b0;
    logic                   timed_out = 1'b0;
    int                     test_errs = 0;
    int                     n_pass = 0;
    int                     n_fail = 0;

    hdcpu_ctrl u_dut (
        .t3(t3), .arst_n(arst_n), .sw(sw), .ir_op(ir_op),
        .w(w), .c(c), .z(z), .ctrl(ctrl)
    );

    initial begin
        t3 = 1'b0;
        forever #20 t3 = ~t3;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge t3);
        arst_n <= 1'b1;
    end

    function automatic hdcpu_pkg::ctrl_word_t ref_ctrl(
        input logic [`HDCPU_SW_W-1:0] mode, input logic [`HDCPU_OP_W-1:0] op,
        input logic [`HDCPU_BEAT_W-1:0] wv, input logic cv, input logic zv, input logic st0);
        hdcpu_pkg::ctrl_word_t r;
        logic w1;
        logic w2;
        logic w3;
        r  = '0;
        w1 = wv[0];
        w2 = wv[1];
        w3 = wv[2];
        case (mode)
            3'b000: begin
                {r.lir, r.pcinc} = {2{w1}};   // Fetch
                case (op)
                    4'b0001: {r.s, r.cin, r.abus, r.drw, r.ldz, r.ldc} = {4'b1001, {5{w2}}};
                    4'b0010: {r.s, r.abus, r.drw, r.ldz, r.ldc} = {4'b0110, {4{w2}}};
                    4'b0011: {r.s, r.m, r.abus, r.drw, r.ldz} = {4'b1011, {4{w2}}};
                    4'b0100: {r.s, r.abus, r.drw, r.ldz, r.ldc} = {4'b0000, {4{w2}}};
                    4'b0101: {r.s, r.m, r.abus, r.lar, r.long, r.drw, r.mbus} =
                        {4'b1010, {4{w2}}, {2{w3}}};
                    4'b0110: {r.s, r.m, r.abus, r.lar, r.long, r.memw} =
                        {w2 ? 4'b1111 : 4'b1010, {2{w2 | w3}}, {2{w2}}, w3};
                    4'b0111: r.pcadd = w2 & cv;
                    4'b1000: r.pcadd = w2 & zv;
                    4'b1001: {r.s, r.m, r.abus, r.lpc} = {4'b1111, {3{w2}}};
                    4'b1010: {r.s, r.m, r.abus} = {4'b1010, {2{w2}}};
                    4'b1100: {r.s, r.m, r.abus, r.drw, r.ldz} = {4'b1110, {4{w2}}};
                    4'b1101: {r.s, r.m, r.abus, r.drw, r.ldz} = {4'b0110, {4{w2}}};
                    4'b1110: r.stop = w2;
                    default: r.s = '0;
                endcase
                if (!(w2 | w3)) begin
                    r.s = '0;
                end
            end
            3'b001: begin
                {r.sbus, r.stop, r.short, r.selctl} = {4{w1}};
                r.lar = w1 & ~st0;
                {r.memw, r.arinc} = {2{w1 & st0}};
            end
            3'b010: begin
                {r.stop, r.short, r.selctl} = {3{w1}};
                {r.sbus, r.lar} = {2{w1 & ~st0}};
                {r.mbus, r.arinc} = {2{w1 & st0}};
            end
            3'b011: begin
                {r.selctl, r.stop} = {2{w1 | w2}};
                r.sel = w1 ? 4'b0001 : (w2 ? 4'b1011 : 4'b0000);
            end
            3'b100: begin
                {r.sbus, r.selctl, r.drw, r.stop} = {4{w1 | w2}};
                case ({st0, w2, w1})
                    3'b001: r.sel = 4'b0011;
                    3'b010: r.sel = 4'b0100;
                    3'b101: r.sel = 4'b1001;
                    3'b110: r.sel = 4'b1110;
                    default: r.sel = '0;
                endcase
            end
            default: r = '0;   // Inactive switch codes
        endcase
        return r;
    endfunction

    function automatic logic next_st0(input logic [`HDCPU_SW_W-1:0] mode,
                                      input logic [`HDCPU_BEAT_W-1:0] wv, input logic st0);
        case (mode)
            3'b001: return st0 | wv[0];
            3'b010: return st0 | wv[0];
            3'b100: return wv[1] ? ~st0 : st0;   // Toggles on each W2
            default: return st0;
        endcase
    endfunction

    task automatic drive_beat(input logic [2:0] m, input logic [3:0] op,
                              input logic [2:0] wv, input logic cv, input logic zv);
        @(posedge t3);
        sw    <= m;
        ir_op <= op;
        w     <= wv;
        c     <= cv;
        z     <= zv;
        pend_word  = ref_ctrl(m, op, wv, cv, zv, st0_model);
        pend_name  = cur_test;
        pend_valid = 1'b1;
        st0_model  = next_st0(m, wv, st0_model);
    endtask

    // WREG W2 with ST0 high is the only way back to ST0 low
    task automatic clear_st0();
        if (st0_model) begin
            drive_beat(3'b100, 4'b0000, 3'b010, 1'b0, 1'b0);
        end
    endtask

    task automatic finish_test();
        int cnt;
        drive_beat(3'b000, 4'b0000, 3'b000, 1'b0, 1'b0);
        cnt = 0;
        while ((pend_valid || cap_valid || exp_q.size() != 0) && cnt < 10) begin
            @(posedge t3);
            cnt++;
        end
        if (pend_valid || cap_valid || exp_q.size() != 0) begin
            $display("timeout: test %s never produced all of its control words", cur_test);
            timed_out = 1'b1;
            test_errs++;
        end
        $display("test %-10s done, %0d mismatches", cur_test, test_errs);
        if (test_errs == 0) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        test_errs = 0;
    endtask

    // Checker runs on the falling edge two stages behind the driver
    always @(negedge t3) begin
        hdcpu_pkg::ctrl_word_t exp_w;
        string nm;
        if (exp_q.size() != 0) begin
            exp_w = exp_q.pop_front();
            nm    = name_q.pop_front();
            if (ctrl !== exp_w) begin
                $display("[FAIL] %s expected %h actual %h", nm, exp_w, ctrl);
                test_errs++;
            end
        end
        if (cap_valid) begin
            exp_q.push_back(cap_word);
            name_q.push_back(cap_name);
        end
        cap_valid  = pend_valid;
        cap_word   = pend_word;
        cap_name   = pend_name;
        pend_valid = 1'b0;
    end

    initial begin
        int cnt;
        logic [2:0] r_sw;
        logic [3:0] r_op;
        logic [2:0] r_w;
        logic r_c;
        logic r_z;
        void'($urandom(32'h4b0c7d9d));
        sw       = '0;
        ir_op    = '0;
        w        = '0;
        c        = 1'b0;
        z        = 1'b0;
        cur_test = "reset";
        cnt      = 0;
        while (!arst_n && cnt < 20) begin
            @(negedge t3);
            if (ctrl !== '0) begin
                $display("[FAIL] %s expected %h actual %h", cur_test, 27'h0, ctrl);
                test_errs++;
            end
            cnt++;
        end
        if (!arst_n) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            @(negedge t3);
            if (ctrl !== '0) begin
                $display("[FAIL] %s expected %h actual %h", cur_test, 27'h0, ctrl);
                test_errs++;
            end
            finish_test();

            cur_test = "exec";
            for (int o = 1; o < 15; o++) begin   // 1011 stands in for an unused code
                for (int cz = 0; cz < 4; cz++) begin
                    for (int b = 0; b < 3; b++) begin
                        drive_beat(3'b000, o[3:0], 3'b001 << b, cz[1], cz[0]);
                    end
                end
            end
            finish_test();

            cur_test = "wmem";
            drive_beat(3'b001, 4'b0000, 3'b001, 1'b0, 1'b0);
            drive_beat(3'b001, 4'b0000, 3'b001, 1'b0, 1'b0);
            finish_test();

            cur_test = "rmem_rreg";
            clear_st0();
            drive_beat(3'b010, 4'b0000, 3'b001, 1'b0, 1'b0);
            drive_beat(3'b010, 4'b0000, 3'b001, 1'b0, 1'b0);
            drive_beat(3'b011, 4'b0000, 3'b001, 1'b0, 1'b0);
            drive_beat(3'b011, 4'b0000, 3'b010, 1'b0, 1'b0);
            finish_test();

            cur_test = "wreg";
            clear_st0();
            for (int p = 0; p < 2; p++) begin
                drive_beat(3'b100, 4'b0000, 3'b001, 1'b0, 1'b0);
                drive_beat(3'b100, 4'b0000, 3'b010, 1'b0, 1'b0);
            end
            for (int m = 5; m < 8; m++) begin
                for (int b = 0; b < 3; b++) begin
                    drive_beat(m[2:0], 4'b0001, 3'b001 << b, 1'b1, 1'b1);
                end
            end
            finish_test();

            cur_test = "random";
            for (int i = 0; i < 300; i++) begin
                r_sw = $urandom_range(7, 0);
                r_op = $urandom_range(15, 0);
                r_w  = 3'b001 << $urandom_range(2, 0);
                r_c  = $urandom_range(1, 0);
                r_z  = $urandom_range(1, 0);
                drive_beat(r_sw, r_op, r_w, r_c, r_z);
            end
            finish_test();
        end
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
hdl/hdcpu_pkg.sv
hdl/beat_sampler.sv
hdl/console_decoder.sv
hdl/instr_decoder.sv
hdl/ctrl_output.sv
hdl/hdcpu_ctrl.sv
verif/hdcpu_tb.sv
